// File: rtl/hdc_pkg.sv
package hdc_pkg;

    // hypervector width, also the bus data width
    localparam int VEC_W = 32;

    // rotate amount held in the low instruction bits
    localparam int ROT_W = 5;

    // interleaved threads and the width of their index
    localparam int THREADS = 5;
    localparam int THREAD_W = 3;

    // item memory geometry
    localparam int ITEM_DEPTH = 64;
    localparam int ITEM_AW = 6;

    // instruction word
    localparam int INST_W = 16;

    // wishbone word address
    localparam int BUS_AW = 8;

    // set selects the control region, clear selects item memory
    localparam int ADR_CTRL_BIT = 7;

    // control region offsets
    localparam logic [ ADR_CTRL_BIT-1:0 ] ADR_INST = 0;
    localparam logic [ ADR_CTRL_BIT-1:0 ] ADR_RESULT = 1;
    localparam logic [ ADR_CTRL_BIT-1:0 ] ADR_STATUS = 2;

    // result queue
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_CW = 3;

    // instruction bit positions
    // address form: load or wb.item
    localparam int OP_ADDR = 15;
    // rotate reg2 before use
    localparam int OP_PERM = 14;
    // load with OP_ADDR, xor without
    localparam int OP_XOR_LOAD = 13;
    // wb.item with OP_ADDR, store without
    localparam int OP_STORE_WB = 12;
    localparam int OP_MOVE = 11;
    localparam int OP_LAST = 10;

endpackage

// File: rtl/hdc_bus_slave.sv
module hdc_bus_slave (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cyc,
    input  logic                                stb,
    input  logic                                we,
    input  logic [ hdc_pkg::BUS_AW-1:0 ]        adr,
    input  logic [ hdc_pkg::VEC_W-1:0 ]         dat_w,
    output logic [ hdc_pkg::VEC_W-1:0 ]         dat_r,
    output logic                                ack,
    output logic                                inst_valid,
    output logic                                restart,
    output logic [ hdc_pkg::INST_W-1:0 ]        inst,
    output logic                                host_we,
    output logic [ hdc_pkg::ITEM_AW-1:0 ]       host_addr,
    output logic [ hdc_pkg::VEC_W-1:0 ]         host_data,
    output logic                                pop,
    input  logic [ hdc_pkg::VEC_W-1:0 ]         head,
    input  logic [ hdc_pkg::FIFO_CW-1:0 ]       count,
    input  logic                                full,
    input  logic                                last
);

    logic                                       is_ctrl;
    logic [ hdc_pkg::ADR_CTRL_BIT-1:0 ]         offset;
    logic                                       inst_wr;
    logic                                       result_rd;
    logic                                       status_acc;
    logic                                       queue_busy;
    logic                                       accept;
    logic [ hdc_pkg::VEC_W-1:0 ]                status_word;
    logic [ hdc_pkg::VEC_W-1:0 ]                rd_word;

    // address map
    assign is_ctrl = adr[ hdc_pkg::ADR_CTRL_BIT ];
    assign offset = adr[ hdc_pkg::ADR_CTRL_BIT-1:0 ];
    assign inst_wr = is_ctrl & we & (offset == hdc_pkg::ADR_INST);
    assign result_rd = is_ctrl & ~we & (offset == hdc_pkg::ADR_RESULT);
    assign status_acc = is_ctrl & (offset == hdc_pkg::ADR_STATUS);
    assign queue_busy = count != '0;

    // instruction writes wait while the queue has no room
    // everything else goes through on the next cycle
    assign accept = cyc & stb & ~ack & ~(inst_wr & full);

    // last in bit 0, queue count from bit 8
    always_comb begin
        status_word = '0;
        status_word[ 0 ] = last;
        status_word[ 8 +: hdc_pkg::FIFO_CW ] = count;
    end

    // empty queue and item reads give zero
    always_comb begin
        rd_word = '0;
        if (result_rd && queue_busy) begin
            rd_word = head;
        end else if (status_acc && !we) begin
            rd_word = status_word;
        end
    end

    // single-cycle ack and command pulses, all in the ack cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
            inst_valid <= 1'b0;
            restart <= 1'b0;
            host_we <= 1'b0;
            pop <= 1'b0;
        end else begin
            ack <= accept;
            inst_valid <= accept & inst_wr;
            restart <= accept & status_acc & we;
            host_we <= accept & we & ~is_ctrl;
            // head was sampled at the same edge, pop lands after it
            pop <= accept & result_rd & queue_busy;
        end
    end

    // data follows the accepted transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            dat_r <= rd_word;
            inst <= dat_w[ hdc_pkg::INST_W-1:0 ];
            host_addr <= adr[ hdc_pkg::ITEM_AW-1:0 ];
            host_data <= dat_w;
        end
    end

endmodule

// File: rtl/hdc_item_memory.sv
module hdc_item_memory (
    input  logic                                clk,
    input  logic                                host_we,
    input  logic [ hdc_pkg::ITEM_AW-1:0 ]       host_addr,
    input  logic [ hdc_pkg::VEC_W-1:0 ]         host_data,
    input  logic                                wb_we,
    input  logic [ hdc_pkg::ITEM_AW-1:0 ]       wb_addr,
    input  logic [ hdc_pkg::VEC_W-1:0 ]         wb_data,
    input  logic [ hdc_pkg::ITEM_AW-1:0 ]       rd_addr,
    output logic [ hdc_pkg::VEC_W-1:0 ]         rd_data
);

    // hypervector store, block ram shaped
    logic [ hdc_pkg::VEC_W-1:0 ]                mem [ hdc_pkg::ITEM_DEPTH ];

    always_ff @(posedge clk) begin
        // bus fill or engine write-back
        // the two never fire in the same cycle
        if (host_we) begin
            mem[ host_addr ] <= host_data;
        end else if (wb_we) begin
            mem[ wb_addr ] <= wb_data;
        end

        // free-running read, consumer picks it up when needed
        rd_data <= mem[ rd_addr ];
    end

endmodule

// File: rtl/hdc_thread_engine.sv
module hdc_thread_engine (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                inst_valid,
    input  logic                                restart,
    input  logic [ hdc_pkg::INST_W-1:0 ]        inst,
    output logic [ hdc_pkg::ITEM_AW-1:0 ]       rd_addr,
    input  logic [ hdc_pkg::VEC_W-1:0 ]         rd_data,
    output logic                                wb_we,
    output logic [ hdc_pkg::ITEM_AW-1:0 ]       wb_addr,
    output logic [ hdc_pkg::VEC_W-1:0 ]         wb_data,
    output logic                                push,
    output logic [ hdc_pkg::VEC_W-1:0 ]         push_data,
    output logic                                last
);

    // decode stage
    logic [ hdc_pkg::THREAD_W-1:0 ]             thread_cnt;

    // execute stage
    logic                                       ex_valid;
    logic [ hdc_pkg::INST_W-1:0 ]               ex_inst;
    logic [ hdc_pkg::THREAD_W-1:0 ]             ex_thread;
    logic [ hdc_pkg::VEC_W-1:0 ]                reg1_q;
    logic [ hdc_pkg::VEC_W-1:0 ]                reg2_q;

    // per-thread register files
    logic [ hdc_pkg::VEC_W-1:0 ]                reg1_file [ hdc_pkg::THREADS ];
    logic [ hdc_pkg::VEC_W-1:0 ]                reg2_file [ hdc_pkg::THREADS ];

    // rotate and operand
    logic [ 2*hdc_pkg::VEC_W-1:0 ]              rot_wide;
    logic [ hdc_pkg::VEC_W-1:0 ]                operand;

    // decoded operations
    logic                                       addr_form;
    logic                                       do_load;
    logic                                       do_wb;
    logic                                       do_xor;
    logic                                       do_store;
    logic                                       do_move;
    logic                                       do_last;

    // load address goes out in the decode cycle
    assign rd_addr = inst[ hdc_pkg::ITEM_AW-1:0 ];

    // round robin over the threads, restart rewinds to thread 0
    always_ff @(posedge clk) begin
        if (rst || restart) begin
            thread_cnt <= '0;
        end else if (inst_valid) begin
            if (thread_cnt == hdc_pkg::THREAD_W'(hdc_pkg::THREADS - 1)) begin
                thread_cnt <= '0;
            end else begin
                thread_cnt <= thread_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= inst_valid;
        end
    end

    // latch the instruction and its thread's registers
    // the previous instruction has already written back by now
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            ex_inst <= inst;
            ex_thread <= thread_cnt;
            reg1_q <= reg1_file[ thread_cnt ];
            reg2_q <= reg2_file[ thread_cnt ];
        end
    end

    // cyclic left rotate by the low instruction bits
    assign rot_wide = {reg2_q, reg2_q} << ex_inst[ hdc_pkg::ROT_W-1:0 ];
    assign operand = ex_inst[ hdc_pkg::OP_PERM ] ?
                     rot_wide[ 2*hdc_pkg::VEC_W-1 -: hdc_pkg::VEC_W ] : reg2_q;

    // address form, load wins over wb.item
    assign addr_form = ex_inst[ hdc_pkg::OP_ADDR ];
    assign do_load = ex_valid & addr_form & ex_inst[ hdc_pkg::OP_XOR_LOAD ];
    assign do_wb = ex_valid & addr_form & ~ex_inst[ hdc_pkg::OP_XOR_LOAD ]
                   & ex_inst[ hdc_pkg::OP_STORE_WB ];

    // plain form: xor, store, move, last, else nop
    assign do_xor = ex_valid & ~addr_form & ex_inst[ hdc_pkg::OP_XOR_LOAD ];
    assign do_store = ex_valid & ~addr_form & ~ex_inst[ hdc_pkg::OP_XOR_LOAD ]
                      & ex_inst[ hdc_pkg::OP_STORE_WB ];
    assign do_move = ex_valid & ~addr_form & ~ex_inst[ hdc_pkg::OP_XOR_LOAD ]
                     & ~ex_inst[ hdc_pkg::OP_STORE_WB ] & ex_inst[ hdc_pkg::OP_MOVE ];
    assign do_last = ex_valid & ~addr_form & ~ex_inst[ hdc_pkg::OP_XOR_LOAD ]
                     & ~ex_inst[ hdc_pkg::OP_STORE_WB ] & ~ex_inst[ hdc_pkg::OP_MOVE ]
                     & ex_inst[ hdc_pkg::OP_LAST ];

    // wb.item writes reg2 as is, low bits carry the address
    assign wb_we = do_wb;
    assign wb_addr = ex_inst[ hdc_pkg::ITEM_AW-1:0 ];
    assign wb_data = reg2_q;

    // store sends the operand to the queue
    assign push = do_store;
    assign push_data = operand;

    // register write-back at the end of the execute cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int t = 0; t < hdc_pkg::THREADS; t++) begin
                reg1_file[ t ] <= '0;
                reg2_file[ t ] <= '0;
            end
        end else begin
            if (do_load) begin
                reg2_file[ ex_thread ] <= rd_data;
            end else if (do_xor) begin
                reg2_file[ ex_thread ] <= reg1_q ^ operand;
            end
            if (do_move) begin
                reg1_file[ ex_thread ] <= operand;
            end
        end
    end

    // sticky until the host restarts
    always_ff @(posedge clk) begin
        if (rst || restart) begin
            last <= 1'b0;
        end else if (do_last) begin
            last <= 1'b1;
        end
    end

endmodule

// File: rtl/hdc_result_fifo.sv
module hdc_result_fifo (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                push,
    input  logic [ hdc_pkg::VEC_W-1:0 ]         push_data,
    input  logic                                pop,
    output logic [ hdc_pkg::VEC_W-1:0 ]         head,
    output logic [ hdc_pkg::FIFO_CW-1:0 ]       count,
    output logic                                full
);

    logic [ hdc_pkg::VEC_W-1:0 ]                mem [ hdc_pkg::FIFO_DEPTH ];
    logic [ $clog2(hdc_pkg::FIFO_DEPTH)-1:0 ]   wr_ptr;
    logic [ $clog2(hdc_pkg::FIFO_DEPTH)-1:0 ]   rd_ptr;
    logic                                       at_cap;
    logic                                       do_push;
    logic                                       do_pop;

    assign at_cap = count == hdc_pkg::FIFO_CW'(hdc_pkg::FIFO_DEPTH);
    assign do_push = push & ~at_cap;
    // popping nothing is a no-op
    assign do_pop = pop & (count != '0);

    // a store in flight already claims the last slot,
    // so the bus cannot ack one instruction too many
    assign full = at_cap | (push & (count == hdc_pkg::FIFO_CW'(hdc_pkg::FIFO_DEPTH - 1)));

    assign head = mem[ rd_ptr ];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[ wr_ptr ] <= push_data;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: rtl/hdc_core_top.sv
module hdc_core_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cyc,
    input  logic                                stb,
    input  logic                                we,
    input  logic [ hdc_pkg::BUS_AW-1:0 ]        adr,
    input  logic [ hdc_pkg::VEC_W-1:0 ]         dat_w,
    output logic [ hdc_pkg::VEC_W-1:0 ]         dat_r,
    output logic                                ack
);

    // bus slave to engine
    logic                                       inst_valid;
    logic                                       restart;
    logic [ hdc_pkg::INST_W-1:0 ]               inst;
    logic                                       last;

    // item memory ports
    logic                                       host_we;
    logic [ hdc_pkg::ITEM_AW-1:0 ]              host_addr;
    logic [ hdc_pkg::VEC_W-1:0 ]                host_data;
    logic                                       wb_we;
    logic [ hdc_pkg::ITEM_AW-1:0 ]              wb_addr;
    logic [ hdc_pkg::VEC_W-1:0 ]                wb_data;
    logic [ hdc_pkg::ITEM_AW-1:0 ]              rd_addr;
    logic [ hdc_pkg::VEC_W-1:0 ]                rd_data;

    // result queue
    logic                                       push;
    logic [ hdc_pkg::VEC_W-1:0 ]                push_data;
    logic                                       pop;
    logic [ hdc_pkg::VEC_W-1:0 ]                head;
    logic [ hdc_pkg::FIFO_CW-1:0 ]              count;
    logic                                       full;

    hdc_bus_slave u_hdc_bus_slave (
        .clk        (clk),
        .rst        (rst),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .dat_r      (dat_r),
        .ack        (ack),
        .inst_valid (inst_valid),
        .restart    (restart),
        .inst       (inst),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_data  (host_data),
        .pop        (pop),
        .head       (head),
        .count      (count),
        .full       (full),
        .last       (last)
    );

    hdc_item_memory u_hdc_item_memory (
        .clk        (clk),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_data  (host_data),
        .wb_we      (wb_we),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    hdc_thread_engine u_hdc_thread_engine (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .restart    (restart),
        .inst       (inst),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .wb_we      (wb_we),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .push       (push),
        .push_data  (push_data),
        .last       (last)
    );

    hdc_result_fifo u_hdc_result_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_data  (push_data),
        .pop        (pop),
        .head       (head),
        .count      (count),
        .full       (full)
    );

endmodule

// File: test/hdc_core_props.sv
module hdc_core_props (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cyc,
    input  logic                                stb,
    input  logic                                we,
    input  logic [ hdc_pkg::BUS_AW-1:0 ]        adr,
    input  logic                                ack,
    input  logic                                full,
    input  logic                                host_we,
    input  logic                                wb_we,
    input  logic                                last
);

    // number of failed assertions
    int fail_count = 0;

    logic                                       inst_req;

    // instruction write waiting for its ack
    assign inst_req = cyc & stb & we & adr[ hdc_pkg::ADR_CTRL_BIT ]
                      & (adr[ hdc_pkg::ADR_CTRL_BIT-1:0 ] == hdc_pkg::ADR_INST);

    // ack is a one-cycle pulse
    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
    else begin
        fail_count++;
        $error("ack high in two consecutive cycles");
    end

    // no ack without a strobe the cycle before
    ack_after_stb: assert property (@(posedge clk) disable iff (rst) ack |-> $past(cyc && stb))
    else begin
        fail_count++;
        $error("ack without a preceding strobe");
    end

    // bus fill and write-back never collide
    one_item_writer: assert property (@(posedge clk) disable iff (rst) !(host_we && wb_we))
    else begin
        fail_count++;
        $error("host and write-back item writes in the same cycle");
    end

    // held instruction gets no ack while the queue is full
    inst_held_full: assert property (@(posedge clk) disable iff (rst)
        (inst_req && full && !ack) |=> !ack)
    else begin
        fail_count++;
        $error("instruction write acknowledged while the queue was full");
    end

    // first cycle out of reset
    quiet_after_rst: assert property (@(posedge clk) ($past(rst) && !rst) |-> (!ack && !last))
    else begin
        fail_count++;
        $error("ack or last high right after reset");
    end

endmodule

bind hdc_core_top hdc_core_props u_hdc_core_props (
    .clk     (clk),
    .rst     (rst),
    .cyc     (cyc),
    .stb     (stb),
    .we      (we),
    .adr     (adr),
    .ack     (ack),
    .full    (full),
    .host_we (host_we),
    .wb_we   (wb_we),
    .last    (last)
);

// File: test/hdc_core_tb.sv
module hdc_core_tb;

    // about 300 transfers of up to 20 cycles each
    localparam int TIMEOUT_CYCLES = 6000;

    // control region addresses
    localparam logic [ hdc_pkg::BUS_AW-1:0 ] INST_ADR = {1'b1, hdc_pkg::ADR_INST};
    localparam logic [ hdc_pkg::BUS_AW-1:0 ] RESULT_ADR = {1'b1, hdc_pkg::ADR_RESULT};
    localparam logic [ hdc_pkg::BUS_AW-1:0 ] STATUS_ADR = {1'b1, hdc_pkg::ADR_STATUS};

    // opcodes with the address or rotate amount or-ed into the low bits
    localparam logic [ 15:0 ] NOP = 16'd0;
    localparam logic [ 15:0 ] PERM = 16'd1 << hdc_pkg::OP_PERM;
    localparam logic [ 15:0 ] LOAD = (16'd1 << hdc_pkg::OP_ADDR) | (16'd1 << hdc_pkg::OP_XOR_LOAD);
    localparam logic [ 15:0 ] WB = (16'd1 << hdc_pkg::OP_ADDR) | (16'd1 << hdc_pkg::OP_STORE_WB);
    localparam logic [ 15:0 ] XOR = 16'd1 << hdc_pkg::OP_XOR_LOAD;
    localparam logic [ 15:0 ] STORE = 16'd1 << hdc_pkg::OP_STORE_WB;
    localparam logic [ 15:0 ] MOVE = 16'd1 << hdc_pkg::OP_MOVE;
    localparam logic [ 15:0 ] LAST = 16'd1 << hdc_pkg::OP_LAST;

    logic                               clk;
    logic                               rst;
    logic                               cyc;
    logic                               stb;
    logic                               we;
    logic [ hdc_pkg::BUS_AW-1:0 ]       adr;
    logic [ 31:0 ]                      dat_w;
    logic [ 31:0 ]                      dat_r;
    logic                               ack;

    // reference model state
    logic [ 31:0 ]                      item_mem [ hdc_pkg::ITEM_DEPTH ];
    logic [ 31:0 ]                      reg1 [ hdc_pkg::THREADS ];
    logic [ 31:0 ]                      reg2 [ hdc_pkg::THREADS ];
    logic [ 31:0 ]                      exp_q [ $ ];
    int                                 written [ $ ];
    int                                 next_thread;
    logic                               last_flag;
    int                                 errors;
    int                                 cycles = 0;

    hdc_core_top u_hdc_core_top (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [ 31:0 ] rotate_left(input logic [ 31:0 ] v, input int n);
        return (v << n) | (v >> (32 - n));
    endfunction

    task automatic drive_bus(input logic req, input logic wr, input logic [ 7:0 ] a,
                             input logic [ 31:0 ] d);
        cyc = req;
        stb = req;
        we = wr;
        adr = a;
        dat_w = d;
    endtask

    // one classic cycle with the strobe held until the ack is taken
    task automatic bus_cycle(input logic wr, input logic [ 7:0 ] a, input logic [ 31:0 ] d,
                             output logic [ 31:0 ] q);
        @(negedge clk);
        drive_bus(1'b1, wr, a, d);
        @(negedge clk);
        while (!ack) begin
            @(negedge clk);
        end
        q = dat_r;
        // strobe stays up across the edge that takes the ack
        @(negedge clk);
        drive_bus(1'b0, 1'b0, a, d);
    endtask

    task automatic compare(input string name, input logic [ 31:0 ] expected,
                           input logic [ 31:0 ] actual);
        assert (actual === expected) else begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic write_item(input logic [ 5:0 ] a, input logic [ 31:0 ] d);
        logic [ 31:0 ] q;
        bus_cycle(1'b1, 8'(a), d, q);
        item_mem[ a ] = d;
        written.push_back(int'(a));
    endtask

    // send one instruction and step the model
    task automatic issue(input logic [ 15:0 ] ins);
        logic [ 31:0 ] q;
        logic [ 31:0 ] op;
        int t;
        bus_cycle(1'b1, INST_ADR, {16'd0, ins}, q);
        t = next_thread;
        next_thread = (next_thread + 1) % hdc_pkg::THREADS;
        op = ins[ hdc_pkg::OP_PERM ] ? rotate_left(reg2[ t ], int'(ins[ 4:0 ])) : reg2[ t ];
        if (ins[ hdc_pkg::OP_ADDR ]) begin
            if (ins[ hdc_pkg::OP_XOR_LOAD ]) begin
                reg2[ t ] = item_mem[ ins[ 5:0 ] ];
            end else if (ins[ hdc_pkg::OP_STORE_WB ]) begin
                item_mem[ ins[ 5:0 ] ] = reg2[ t ];
            end
        end else if (ins[ hdc_pkg::OP_XOR_LOAD ]) begin
            reg2[ t ] = reg1[ t ] ^ op;
        end else if (ins[ hdc_pkg::OP_STORE_WB ]) begin
            exp_q.push_back(op);
        end else if (ins[ hdc_pkg::OP_MOVE ]) begin
            reg1[ t ] = op;
        end else if (ins[ hdc_pkg::OP_LAST ]) begin
            last_flag = 1'b1;
        end
    endtask

    task automatic read_result(input string name);
        logic [ 31:0 ] q;
        bus_cycle(1'b0, RESULT_ADR, '0, q);
        compare(name, (exp_q.size() > 0) ? exp_q.pop_front() : 32'd0, q);
    endtask

    task automatic read_status(input string name);
        logic [ 31:0 ] q;
        bus_cycle(1'b0, STATUS_ADR, '0, q);
        compare(name, {21'd0, 3'(exp_q.size()), 7'd0, last_flag}, q);
    endtask

    // strobe an instruction write for a few cycles without getting an ack
    task automatic hold_instruction(input logic [ 15:0 ] ins);
        @(negedge clk);
        drive_bus(1'b1, 1'b1, INST_ADR, {16'd0, ins});
        repeat (4) begin
            @(negedge clk);
            assert (!ack) else begin
                errors++;
                $display("instruction write was acknowledged while the queue was full");
            end
        end
        drive_bus(1'b0, 1'b0, INST_ADR, '0);
    endtask

    initial begin
        logic [ 31:0 ] q;
        logic [ 5:0 ] a;
        logic [ 15:0 ] perm;
        int sel;
        void'($urandom(32'h3138_631e));
        clk = 1'b0;
        rst = 1'b1;
        drive_bus(1'b0, 1'b0, '0, '0);
        errors = 0;
        next_thread = 0;
        last_flag = 1'b0;
        for (int t = 0; t < hdc_pkg::THREADS; t++) begin
            reg1[ t ] = '0;
            reg2[ t ] = '0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // load five vectors into the five threads and store them back
        repeat (2) begin
            for (int i = 0; i < hdc_pkg::THREADS; i++) begin
                write_item(6'($urandom), $urandom);
            end
            for (int i = 0; i < hdc_pkg::THREADS; i++) begin
                issue(LOAD | 16'(written[ written.size() - hdc_pkg::THREADS + i ]));
            end
            for (int i = 0; i < hdc_pkg::THREADS; i++) begin
                issue(STORE);
                read_result("load_store");
            end
        end
        // item space reads back as zero
        bus_cycle(1'b0, 8'(written[ 0 ]), '0, q);
        compare("item_read", '0, q);

        // random mix over the interleaved threads
        repeat (40) begin
            sel = int'($urandom % 4);
            perm = ($urandom % 2 == 1) ? PERM : NOP;
            case (sel)
                0: issue(LOAD | 16'(written[ $urandom % written.size() ]));
                1: issue(MOVE | perm | 16'(5'($urandom)));
                2: issue(XOR | perm | 16'(5'($urandom)));
                default: begin
                    issue(STORE | perm | 16'(5'($urandom)));
                    read_result("thread_mix");
                end
            endcase
        end

        // rotates on xor and store
        repeat (10) begin
            issue(XOR | PERM | 16'(5'($urandom)));
            issue(STORE | PERM | 16'(5'($urandom)));
            read_result("permute");
        end

        // wb.item on thread t then load and a later store on thread t+1
        repeat (3) begin
            a = 6'($urandom);
            issue(WB | 16'(a));
            // host fill right behind the write-back, neighbouring address
            write_item(a ^ 6'd1, $urandom);
            issue(LOAD | 16'(a));
            repeat (hdc_pkg::THREADS - 1) issue(NOP);
            issue(STORE);
            read_result("write_back");
        end

        // fill the queue and stall one instruction before draining
        repeat (hdc_pkg::FIFO_DEPTH) issue(STORE);
        read_status("queue_full");
        hold_instruction(STORE);
        read_result("back_pressure");
        issue(STORE);
        while (exp_q.size() > 0) begin
            read_result("drain");
        end
        read_result("empty_read");

        // last stays set until a status write rewinds to thread 0
        issue(LAST);
        read_status("last_set");
        bus_cycle(1'b1, STATUS_ADR, '0, q);
        last_flag = 1'b0;
        next_thread = 0;
        read_status("last_cleared");
        issue(STORE);
        read_result("restart_thread");

        $display("errors: %0d check, %0d assertion", errors,
                 u_hdc_core_top.u_hdc_core_props.fail_count);
        if (errors == 0 && u_hdc_core_top.u_hdc_core_props.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
rtl/hdc_pkg.sv
rtl/hdc_bus_slave.sv
rtl/hdc_item_memory.sv
rtl/hdc_thread_engine.sv
rtl/hdc_result_fifo.sv
rtl/hdc_core_top.sv
test/hdc_core_props.sv
test/hdc_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the hdc core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module hdc_core_tb \
    -f files.f --Mdir obj_dir -o hdc_core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/hdc_core_sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
echo "pass message not found"
exit 1
